// ==== backend.f ====
verilog/backend_pkg.sv
verilog/int_regfile.sv
verilog/int_alu.sv
verilog/instr_decoder.sv
verilog/lsu_wb.sv
verilog/backend_ctrl.sv
verilog/backend.sv
verif/tb_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_backend -f backend.f -o tb_backend

./obj_dir/tb_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== verif/tb_backend.sv ====
// Table-driven testbench for the RV32I backend with a Wishbone memory model.
`default_nettype none

module tb_backend import backend_pkg::*; ();

  localparam int TIMEOUT   = 40;
  localparam int MEM_WORDS = 64;

  // one instruction and what it must report when it retires.
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] pred_npc;
    logic        we;
    logic [4:0]  areg;
    logic [31:0] wdata;
    logic        flush;
    logic [31:0] flush_pc;
    logic        br;
    logic        cond;
    logic        taken;
    logic [31:0] target;
  } row_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        fetch_valid;
  fetch_t      fetch;
  logic        fetch_ready;
  logic        flush_in;
  wb_req_t     wb;
  logic [31:0] wb_dat = '0;
  logic        wb_ack = 1'b0;
  commit_t     commit;
  bpu_upd_t    bpu_update;
  logic        flush;
  logic [31:0] flush_pc;

  logic [31:0] mem [MEM_WORDS];
  row_t        rows [$];
  integer      seed = 32'h737;
  int          ack_wait = 0;
  logic        pending = 1'b0;
  logic [31:0] held_adr = '0;

  always #50 clk = ~clk;

  backend #(
    .BOOT_PC(32'h0000_0100)
  ) backend_inst (
    .clk_i         (clk),
    .reset_i       (reset),
    .fetch_valid_i (fetch_valid),
    .fetch_i       (fetch),
    .fetch_ready_o (fetch_ready),
    .flush_i       (flush_in),
    .wb_o          (wb),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack),
    .commit_o      (commit),
    .bpu_update_o  (bpu_update),
    .flush_o       (flush),
    .flush_pc_o    (flush_pc)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] fill_word(input int idx);
    return 32'hc0de_0000 | (32'(idx) << 2);
  endfunction

  // word memory; ack comes 0 to 3 cycles after stb is first seen.
  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i[5:0]] = fill_word(i);
      end
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb.cyc && wb.stb) begin
      if (!pending) begin
        pending  = 1'b1;
        ack_wait = $random(seed) & 3;
        held_adr = wb.adr;
      end
      check("wb_o.adr", wb.adr, held_adr);
      check("wb_o.sel", 32'(wb.sel), 32'hf);
      if (ack_wait == 0) begin
        if (wb.we) begin
          mem[wb.adr[7:2]] = wb.dat_w;
        end
        wb_dat  = mem[wb.adr[7:2]];
        wb_ack  = 1'b1;
        pending = 1'b0;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  task automatic op_row(input logic [31:0] instr, input logic [31:0] pc, input logic we,
                        input logic [4:0] areg, input logic [31:0] wdata);
    row_t row;
    row          = '0;
    row.instr    = instr;
    row.pc       = pc;
    row.pred_npc = pc + 32'd4;
    row.we       = we;
    row.areg     = areg;
    row.wdata    = wdata;
    rows.push_back(row);
  endtask

  // jumps are the unconditional rows and link pc+4.
  task automatic br_row(input logic [31:0] instr, input logic [31:0] pc,
                        input logic [31:0] pred_npc, input logic [4:0] areg,
                        input logic cond, input logic taken, input logic [31:0] target);
    row_t        row;
    logic [31:0] npc;
    npc          = taken ? target : pc + 32'd4;
    row          = '0;
    row.instr    = instr;
    row.pc       = pc;
    row.pred_npc = pred_npc;
    row.we       = !cond;
    row.areg     = areg;
    row.wdata    = pc + 32'd4;
    row.flush    = npc != pred_npc;
    row.flush_pc = npc;
    row.br       = 1'b1;
    row.cond     = cond;
    row.taken    = taken;
    row.target   = target;
    rows.push_back(row);
  endtask

  task automatic build_table();
    op_row(32'h00500093, 32'h100, 1'b1, 5'd1, 32'h00000005);
    op_row(32'hffd00113, 32'h104, 1'b1, 5'd2, 32'hfffffffd);
    op_row(32'h002081b3, 32'h108, 1'b1, 5'd3, 32'h00000002);
    op_row(32'h40208233, 32'h10c, 1'b1, 5'd4, 32'h00000008);
    op_row(32'h0020f2b3, 32'h110, 1'b1, 5'd5, 32'h00000005);
    op_row(32'h0020e333, 32'h114, 1'b1, 5'd6, 32'hfffffffd);
    op_row(32'h0020c3b3, 32'h118, 1'b1, 5'd7, 32'hfffffff8);
    op_row(32'h00309413, 32'h11c, 1'b1, 5'd8, 32'h00000028);
    op_row(32'h40115493, 32'h120, 1'b1, 5'd9, 32'hfffffffe);
    op_row(32'h00415513, 32'h124, 1'b1, 5'd10, 32'h0fffffff);
    op_row(32'h001125b3, 32'h128, 1'b1, 5'd11, 32'h00000001);
    op_row(32'h00113633, 32'h12c, 1'b1, 5'd12, 32'h00000000);
    // x0 commits the sum, then reads back as zero.
    op_row(32'h00708013, 32'h130, 1'b1, 5'd0, 32'h0000000c);
    op_row(32'h000006b3, 32'h134, 1'b1, 5'd13, 32'h00000000);
    op_row(32'h04000713, 32'h138, 1'b1, 5'd14, 32'h00000040);
    op_row(32'h00672423, 32'h13c, 1'b0, 5'd0, 32'h0);
    op_row(32'h00772623, 32'h140, 1'b0, 5'd0, 32'h0);
    op_row(32'h00872783, 32'h144, 1'b1, 5'd15, 32'hfffffffd);
    op_row(32'h00c72803, 32'h148, 1'b1, 5'd16, 32'hfffffff8);
    op_row(32'h00072883, 32'h14c, 1'b1, 5'd17, fill_word(16));
    br_row(32'h00128863, 32'h150, 32'h160, 5'd0, 1'b1, 1'b1, 32'h160);
    br_row(32'hfed09ce3, 32'h160, 32'h164, 5'd0, 1'b1, 1'b1, 32'h158);
    br_row(32'h00129463, 32'h158, 32'h160, 5'd0, 1'b1, 1'b0, 32'h160);
    br_row(32'h0200096f, 32'h15c, 32'h17c, 5'd18, 1'b0, 1'b1, 32'h17c);
    br_row(32'h005709e7, 32'h17c, 32'h180, 5'd19, 1'b0, 1'b1, 32'h044);
    op_row(32'h01390a33, 32'h044, 1'b1, 5'd20, 32'h000002e0);
  endtask

  task automatic run_row(input row_t row);
    int cycles;
    cycles = 0;
    while (!fetch_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run("timeout while waiting for fetch_ready_o");
      end
    end
    fetch_valid = 1'b1;
    fetch       = '{instr: row.instr, pc: row.pc, pred_npc: row.pred_npc};
    @(negedge clk);
    check("fetch_ready_o", 32'(fetch_ready), 32'd0);
    // a different instruction offered while busy must not be taken.
    fetch  = '{instr: 32'h7ff00293, pc: 32'hdead_beef, pred_npc: 32'h0};
    cycles = 1;
    while (!commit.valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run("timeout while waiting for commit_o.valid");
      end
    end
    fetch_valid = 1'b0;
    if (row.instr[6:0] != 7'h03 && row.instr[6:0] != 7'h23) begin
      check("retire latency", 32'(cycles), 32'd2);
    end
    check("commit_o.we", 32'(commit.we), 32'(row.we));
    if (row.we) begin
      check("commit_o.areg", 32'(commit.areg), 32'(row.areg));
      check("commit_o.wdata", commit.wdata, row.wdata);
    end
    check("flush_o", 32'(flush), 32'(row.flush));
    if (row.flush) begin
      check("flush_pc_o", flush_pc, row.flush_pc);
    end
    check("bpu_update_o.valid", 32'(bpu_update.valid), 32'(row.br));
    if (row.br) begin
      check("bpu_update_o.pc", bpu_update.pc, row.pc);
      check("bpu_update_o.is_cond", 32'(bpu_update.is_cond), 32'(row.cond));
      check("bpu_update_o.taken", 32'(bpu_update.taken), 32'(row.taken));
      check("bpu_update_o.target", bpu_update.target, row.target);
    end
    @(negedge clk);
    check("commit_o.valid", 32'(commit.valid), 32'd0);
    check("fetch_ready_o", 32'(fetch_ready), 32'd1);
  endtask

  initial begin
    reset       = 1'b1;
    fetch_valid = 1'b0;
    fetch       = '0;
    flush_in    = 1'b0;
    build_table();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check("commit_o.valid", 32'(commit.valid), 32'd0);
    check("bpu_update_o.valid", 32'(bpu_update.valid), 32'd0);
    check("flush_o", 32'(flush), 32'd0);
    check("wb_o.cyc", 32'(wb.cyc), 32'd0);
    check("wb_o.stb", 32'(wb.stb), 32'd0);
    check("fetch_ready_o", 32'(fetch_ready), 32'd1);
    foreach (rows[r]) begin
      run_row(rows[r]);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/backend.sv ====
// In-order RV32I backend top: control, decode, register file, ALU and Wishbone LSU.
`default_nettype none

module backend import backend_pkg::*; #(
  parameter logic [XLEN-1:0] BOOT_PC = '0
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            fetch_valid_i,
  input  fetch_t          fetch_i,
  output logic            fetch_ready_o,
  input  logic            flush_i,
  output wb_req_t         wb_o,
  input  logic [31:0]     wb_dat_i,
  input  logic            wb_ack_i,
  output commit_t         commit_o,
  output bpu_upd_t        bpu_update_o,
  output logic            flush_o,
  output logic [31:0]     flush_pc_o
);

  instr_u          instr;
  uop_t            uop;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_res;
  logic            br_taken;
  logic [XLEN-1:0] br_target;
  logic            mem_start;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_we;
  logic            mem_done;
  logic [XLEN-1:0] mem_rdata;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  backend_ctrl #(
    .BOOT_PC(BOOT_PC)
  ) ctrl_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .flush_i       (flush_i),
    .instr_o       (instr),
    .pc_o          (pc),
    .uop_i         (uop),
    .rs2_i         (rs2_data),
    .alu_res_i     (alu_res),
    .br_taken_i    (br_taken),
    .br_target_i   (br_target),
    .mem_start_o   (mem_start),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_we_o      (mem_we),
    .mem_done_i    (mem_done),
    .mem_rdata_i   (mem_rdata),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .commit_o      (commit_o),
    .bpu_update_o  (bpu_update_o),
    .flush_o       (flush_o),
    .flush_pc_o    (flush_pc_o)
  );

  instr_decoder decoder_inst (
    .instr_i (instr),
    .uop_o   (uop)
  );

  int_regfile regfile_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .raddr1_i (uop.rs1),
    .raddr2_i (uop.rs2),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  int_alu alu_inst (
    .uop_i       (uop),
    .rs1_i       (rs1_data),
    .rs2_i       (rs2_data),
    .pc_i        (pc),
    .res_o       (alu_res),
    .br_taken_o  (br_taken),
    .br_target_o (br_target)
  );

  lsu_wb lsu_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (mem_start),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .wb_o     (wb_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .done_o   (mem_done),
    .rdata_o  (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== verilog/backend_ctrl.sv ====
// Backend sequencer: accepts one instruction, executes it, waits on memory and retires it.
`default_nettype none

module backend_ctrl import backend_pkg::*; #(
  parameter logic [XLEN-1:0] BOOT_PC = '0
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            fetch_valid_i,
  input  fetch_t          fetch_i,
  output logic            fetch_ready_o,
  input  logic            flush_i,
  output instr_u          instr_o,
  output logic [XLEN-1:0] pc_o,
  input  uop_t            uop_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic [XLEN-1:0] alu_res_i,
  input  logic            br_taken_i,
  input  logic [XLEN-1:0] br_target_i,
  output logic            mem_start_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  output logic            mem_we_o,
  input  logic            mem_done_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  output logic            rf_we_o,
  output logic [4:0]      rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,
  output commit_t         commit_o,
  output bpu_upd_t        bpu_update_o,
  output logic            flush_o,
  output logic [XLEN-1:0] flush_pc_o
);

  typedef enum logic [1:0] {
    S_IDLE, S_DECODE, S_EXEC, S_MEM
  } state_e;

  state_e          state_q;
  fetch_t          fetch_q;
  logic            kill_q;
  logic            is_mem;
  logic            is_br;
  logic            is_link;
  logic            retire;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;

  assign is_mem   = uop_i.mem_op != MEM_NONE;
  assign is_br    = uop_i.br_cond != BR_NONE;
  assign is_link  = (uop_i.br_cond == BR_JAL) || (uop_i.br_cond == BR_JALR);
  assign pc_plus4 = fetch_q.pc + 32'd4;
  assign next_pc  = br_taken_i ? br_target_i : pc_plus4;

  assign fetch_ready_o = state_q == S_IDLE;
  assign instr_o       = fetch_q.instr;
  assign pc_o          = fetch_q.pc;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
      kill_q  <= 1'b0;
      fetch_q <= '{instr: '0, pc: BOOT_PC, pred_npc: BOOT_PC};
    end else begin
      case (state_q)
        S_IDLE: begin
          if (fetch_valid_i) begin
            fetch_q <= fetch_i;
            state_q <= S_DECODE;
          end
        end
        // operands are read from the register file during this cycle.
        S_DECODE: state_q <= flush_i ? S_IDLE : S_EXEC;
        S_EXEC: begin
          kill_q  <= 1'b0;
          state_q <= (is_mem && !flush_i) ? S_MEM : S_IDLE;
        end
        default: begin
          // a bus cycle cannot be abandoned, so a flush only cancels the retire.
          if (flush_i) begin
            kill_q <= 1'b1;
          end
          if (mem_done_i) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_comb begin
    case (state_q)
      S_EXEC:  retire = !is_mem && !flush_i;
      S_MEM:   retire = mem_done_i && !kill_q && !flush_i;
      default: retire = 1'b0;
    endcase
  end

  assign mem_start_o = (state_q == S_EXEC) && is_mem && !flush_i;
  assign mem_addr_o  = alu_res_i;
  assign mem_wdata_o = rs2_i;
  assign mem_we_o    = uop_i.mem_op == MEM_STORE;

  // link registers take pc+4, loads take bus data.
  always_comb begin
    if (uop_i.mem_op == MEM_LOAD) begin
      rf_wdata_o = mem_rdata_i;
    end else if (is_link) begin
      rf_wdata_o = pc_plus4;
    end else begin
      rf_wdata_o = alu_res_i;
    end
  end

  assign rf_we_o    = retire && uop_i.reg_we;
  assign rf_waddr_o = uop_i.rd;

  assign commit_o = '{valid: retire, we: uop_i.reg_we, areg: uop_i.rd, wdata: rf_wdata_o};

  assign bpu_update_o = '{
    valid:   retire && is_br,
    pc:      fetch_q.pc,
    is_cond: is_br && !is_link,
    taken:   br_taken_i,
    target:  br_target_i
  };

  assign flush_o    = retire && is_br && (next_pc != fetch_q.pred_npc);
  assign flush_pc_o = next_pc;

  // only branch and jump opcodes may redirect fetch.
  a_flush_on_branch: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_o |-> fetch_q.instr[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111});

  // the decoder flags encodings this core does not implement.
  a_no_illegal: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_o.valid |-> !uop_i.illegal);

endmodule

`default_nettype wire

// ==== verilog/backend_pkg.sv ====
// Backend shared types: instruction formats, micro-op and bus/retirement records.
`default_nettype none

package backend_pkg;

  localparam int XLEN = 32;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // one instruction word, viewed in whichever format the opcode calls for.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  // nine conditions, so this needs a fourth bit.
  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_cond_e;

  typedef enum logic [1:0] {
    MEM_NONE, MEM_LOAD, MEM_STORE
  } mem_op_e;

  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            reg_we;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    alu_op_e         alu_op;
    br_cond_e        br_cond;
    mem_op_e         mem_op;
    logic            illegal;
  } uop_t;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pred_npc;
  } fetch_t;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [4:0]      areg;
    logic [XLEN-1:0] wdata;
  } commit_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            is_cond;
    logic            taken;
    logic [XLEN-1:0] target;
  } bpu_upd_t;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat_w;
    logic [3:0]      sel;
  } wb_req_t;

endpackage

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
// RV32I decoder: builds a micro-op with immediate, operand selects and unit controls.
`default_nettype none

module instr_decoder import backend_pkg::*; (
  input  instr_u instr_i,
  output uop_t   uop_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  function automatic alu_op_e alu_op_of(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  logic [2:0] funct3;
  logic [6:0] imm_top;

  assign funct3  = instr_i.r.funct3;
  assign imm_top = instr_i.i.imm[11:5];

  always_comb begin
    uop_o     = '0;
    uop_o.rs1 = instr_i.r.rs1;
    uop_o.rs2 = instr_i.r.rs2;
    uop_o.rd  = instr_i.r.rd;
    case (instr_i.r.opcode)
      OPC_OP: begin
        uop_o.reg_we  = 1'b1;
        uop_o.alu_op  = alu_op_of(funct3, instr_i.r.funct7[5]);
        uop_o.illegal = (instr_i.r.funct7 != 7'h00) &&
                        !(instr_i.r.funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_OP_IMM: begin
        uop_o.reg_we  = 1'b1;
        uop_o.use_imm = 1'b1;
        uop_o.imm     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        // only the right shift uses bit 30 to pick its arithmetic form.
        uop_o.alu_op  = alu_op_of(funct3, funct3 == 3'b101 && imm_top[5]);
        uop_o.illegal = (funct3 == 3'b001 && imm_top != 7'h00) ||
                        (funct3 == 3'b101 && imm_top != 7'h00 && imm_top != 7'h20);
      end
      OPC_LOAD: begin
        uop_o.reg_we  = 1'b1;
        uop_o.use_imm = 1'b1;
        uop_o.imm     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        uop_o.mem_op  = MEM_LOAD;
        uop_o.illegal = funct3 != 3'b010;
      end
      OPC_STORE: begin
        uop_o.use_imm = 1'b1;
        uop_o.imm     = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
        uop_o.mem_op  = MEM_STORE;
        uop_o.illegal = funct3 != 3'b010;
      end
      OPC_BRANCH: begin
        uop_o.imm = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                     instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
        case (funct3)
          3'b000:  uop_o.br_cond = BR_EQ;
          3'b001:  uop_o.br_cond = BR_NE;
          3'b100:  uop_o.br_cond = BR_LT;
          3'b101:  uop_o.br_cond = BR_GE;
          3'b110:  uop_o.br_cond = BR_LTU;
          3'b111:  uop_o.br_cond = BR_GEU;
          default: uop_o.illegal = 1'b1;
        endcase
      end
      OPC_JAL: begin
        uop_o.reg_we  = 1'b1;
        uop_o.br_cond = BR_JAL;
        uop_o.imm     = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      end
      OPC_JALR: begin
        uop_o.reg_we  = 1'b1;
        uop_o.br_cond = BR_JALR;
        uop_o.imm     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        uop_o.illegal = funct3 != 3'b000;
      end
      OPC_LUI: begin
        // x0 plus the upper immediate.
        uop_o.rs1     = 5'd0;
        uop_o.reg_we  = 1'b1;
        uop_o.use_imm = 1'b1;
        uop_o.imm     = {instr_i[31:12], 12'b0};
      end
      default: uop_o.illegal = 1'b1;
    endcase
    if (uop_o.illegal) begin
      uop_o.reg_we  = 1'b0;
      uop_o.mem_op  = MEM_NONE;
      uop_o.br_cond = BR_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/int_alu.sv ====
// Integer ALU: arithmetic, logic, shifts, compares, branch decision and target.
`default_nettype none

module int_alu import backend_pkg::*; (
  input  uop_t            uop_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] res_o,
  output logic            br_taken_o,
  output logic [XLEN-1:0] br_target_o
);

  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] jalr_sum;

  assign op_b     = uop_i.use_imm ? uop_i.imm : rs2_i;
  assign shamt    = op_b[4:0];
  assign jalr_sum = rs1_i + uop_i.imm;

  always_comb begin
    case (uop_i.alu_op)
      ALU_SUB:  res_o = rs1_i - op_b;
      ALU_AND:  res_o = rs1_i & op_b;
      ALU_OR:   res_o = rs1_i | op_b;
      ALU_XOR:  res_o = rs1_i ^ op_b;
      ALU_SLL:  res_o = rs1_i << shamt;
      ALU_SRL:  res_o = rs1_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(rs1_i) >>> shamt);
      ALU_SLT:  res_o = {31'b0, $signed(rs1_i) < $signed(op_b)};
      ALU_SLTU: res_o = {31'b0, rs1_i < op_b};
      default:  res_o = rs1_i + op_b;
    endcase
  end

  // branches always compare the two registers.
  always_comb begin
    case (uop_i.br_cond)
      BR_EQ:   br_taken_o = rs1_i == rs2_i;
      BR_NE:   br_taken_o = rs1_i != rs2_i;
      BR_LT:   br_taken_o = $signed(rs1_i) < $signed(rs2_i);
      BR_GE:   br_taken_o = $signed(rs1_i) >= $signed(rs2_i);
      BR_LTU:  br_taken_o = rs1_i < rs2_i;
      BR_GEU:  br_taken_o = rs1_i >= rs2_i;
      BR_JAL,
      BR_JALR: br_taken_o = 1'b1;
      default: br_taken_o = 1'b0;
    endcase
  end

  assign br_target_o = (uop_i.br_cond == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                   : pc_i + uop_i.imm;

endmodule

`default_nettype wire

// ==== verilog/int_regfile.sv ====
// Integer register file: 32 x 32 bits, two combinational reads, one write, x0 tied to zero.
`default_nettype none

module int_regfile import backend_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic [4:0]      raddr1_i,
  input  logic [4:0]      raddr2_i,
  output logic [XLEN-1:0] rdata1_o,
  output logic [XLEN-1:0] rdata2_o,
  input  logic            we_i,
  input  logic [4:0]      waddr_i,
  input  logic [XLEN-1:0] wdata_i
);

  logic [XLEN-1:0] regs_q [32];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is never written, so it reads back zero.
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

`default_nettype wire

// ==== verilog/lsu_wb.sv ====
// Load/store unit: single-word Wishbone classic master.
`default_nettype none

module lsu_wb import backend_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  logic            we_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output wb_req_t         wb_o,
  input  logic [XLEN-1:0] wb_dat_i,
  input  logic            wb_ack_i,
  output logic            done_o,
  output logic [XLEN-1:0] rdata_o
);

  logic            busy_q;
  logic            done_q;
  logic            we_q;
  logic [XLEN-1:0] adr_q;
  logic [XLEN-1:0] dat_q;
  logic [XLEN-1:0] rdata_q;
  logic            cyc;

  // the request goes out in the start cycle and is then held from the latches.
  assign cyc = start_i || busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= cyc && wb_ack_i;
      if (start_i && !wb_ack_i) begin
        busy_q <= 1'b1;
      end else if (wb_ack_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      we_q  <= we_i;
      adr_q <= addr_i;
      dat_q <= wdata_i;
    end
    if (cyc && wb_ack_i) begin
      rdata_q <= wb_dat_i;
    end
  end

  assign wb_o = '{
    cyc:   cyc,
    stb:   cyc,
    we:    busy_q ? we_q : we_i,
    adr:   busy_q ? adr_q : addr_i,
    dat_w: busy_q ? dat_q : wdata_i,
    sel:   4'hf
  };

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

  a_no_start_while_open: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> !busy_q);

endmodule

`default_nettype wire
